/* hw/axi_access_fsm.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_access_fsm
  import dbg_req_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              axi_aclk,
  input  logic              axi_aresetn,
  // Start request from the TCK side
  input  logic              start_pulse_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  input  lane_mask_t        req_strb_i,
  input  axi_size_t         req_size_i,
  input  logic              req_write_i,
  // Write address channel
  output logic              aw_valid_o,
  output logic [ADDR_W-1:0] aw_addr_o,
  output axi_size_t         aw_size_o,
  input  logic              aw_ready_i,
  // Write data channel
  output logic              w_valid_o,
  output logic [DATA_W-1:0] w_data_o,
  output lane_mask_t        w_strb_o,
  input  logic              w_ready_i,
  // Read address channel
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  output axi_size_t         ar_size_o,
  input  logic              ar_ready_i,
  // Read data channel
  input  logic              r_valid_i,
  input  logic [DATA_W-1:0] r_data_i,
  input  axi_resp_t         r_resp_i,
  output logic              r_ready_o,
  // Write response channel
  input  logic              b_valid_i,
  input  axi_resp_t         b_resp_i,
  output logic              b_ready_o,
  // Result toward the debug side
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic              done_toggle_o
);

  fsm_state_t        state_q;
  fsm_state_t        state_d;
  // Write beat taken before the address
  logic              w_sent_q;
  logic              done;
  lane_off_t         rd_off;
  logic [DATA_W-1:0] rdata_aligned;

  // Request registers drive the address and data fields directly
  assign aw_addr_o = req_addr_i;
  assign ar_addr_o = req_addr_i;
  assign aw_size_o = req_size_i;
  assign ar_size_o = req_size_i;
  assign w_data_o  = req_wdata_i;
  assign w_strb_o  = req_strb_i;

  //////////////////////////////
  // Transfer sequencer
  //////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    b_ready_o  = 1'b0;
    r_ready_o  = 1'b0;
    done       = 1'b0;
    case (state_q)
      IDLE:
        if (start_pulse_i)
          state_d = ADDR;
      ADDR:
        if (req_write_i)
        begin
          aw_valid_o = 1'b1;
          // Data beat is offered until it is taken once
          w_valid_o  = ~w_sent_q;
          if (aw_ready_i)
            state_d = (w_sent_q || w_ready_i) ? RESP : DATA;
        end
        else
        begin
          ar_valid_o = 1'b1;
          if (ar_ready_i)
            state_d = RESP;
        end
      DATA:
      begin
        w_valid_o = 1'b1;
        if (w_ready_i)
          state_d = RESP;
      end
      RESP:
      begin
        b_ready_o = req_write_i;
        r_ready_o = ~req_write_i;
        done      = req_write_i ? b_valid_i : r_valid_i;
        if (done)
          state_d = IDLE;
      end
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge axi_aclk, negedge axi_aresetn)
  begin
    if (!axi_aresetn)
    begin
      state_q  <= IDLE;
      w_sent_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Remember an early write handshake in ADDR
      if (state_q == ADDR && w_valid_o && w_ready_i && !aw_ready_i)
        w_sent_q <= 1'b1;
      else if (state_q != ADDR)
        w_sent_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Read alignment and result
  //////////////////////////////

  // Lowest strobe bit marks the lane offset
  always_comb
  begin
    rd_off = '0;
    for (int i = LANES - 1; i >= 0; i--)
      if (req_strb_i[i])
        rd_off = lane_off_t'(i);
  end

  // Selected bytes down to lane 0 with zero fill
  assign rdata_aligned = r_data_i >> {rd_off, 3'b000};

  always_ff @(posedge axi_aclk)
  begin
    if (done && !req_write_i)
      rdata_o <= rdata_aligned;
  end

  always_ff @(posedge axi_aclk, negedge axi_aresetn)
  begin
    if (!axi_aresetn)
    begin
      err_o         <= 1'b0;
      done_toggle_o <= 1'b0;
    end
    else if (done)
    begin
      // Any response other than OKAY flags an error
      err_o         <= req_write_i ? (b_resp_i != AXI_RESP_OKAY)
                                   : (r_resp_i != AXI_RESP_OKAY);
      done_toggle_o <= ~done_toggle_o;
    end
  end

endmodule

`default_nettype wire

/* hw/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

  // AXI transfer size code
  // Equals log2 of the number of bytes in the beat
  typedef logic [2:0] axi_size_t;

  // Response field on the r and b channels
  typedef logic [1:0] axi_resp_t;

  // Only OKAY counts as success
  // EXOKAY, SLVERR and DECERR all raise the debug error flag
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Transfer sequencer states
  // IDLE waits for a start pulse from the TCK side
  // ADDR presents the address channel (and write data)
  // DATA holds write data after the address was taken
  // RESP waits for the b or r response
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    RESP
  } fsm_state_t;

endpackage

`default_nettype wire

/* hw/dbg_axi_biu.sv */
`default_nettype none
`timescale 1ns/100ps

module dbg_axi_biu
  import dbg_req_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  // Debug side, TCK domain
  input  logic              tck_i,
  input  logic              trstn_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] data_i,
  input  word_size_t        word_size_i,
  input  logic              rd_wrn_i,
  input  logic              strobe_i,
  output logic [DATA_W-1:0] data_o,
  output logic              rdy_o,
  output logic              err_o,
  // AXI master, axi_aclk domain
  input  logic              axi_aclk,
  input  logic              axi_aresetn,
  output logic              aw_valid_o,
  output logic [ADDR_W-1:0] aw_addr_o,
  output axi_size_t         aw_size_o,
  input  logic              aw_ready_i,
  output logic              w_valid_o,
  output logic [DATA_W-1:0] w_data_o,
  output lane_mask_t        w_strb_o,
  input  logic              w_ready_i,
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  output axi_size_t         ar_size_o,
  input  logic              ar_ready_i,
  input  logic              r_valid_i,
  input  logic [DATA_W-1:0] r_data_i,
  input  axi_resp_t         r_resp_i,
  output logic              r_ready_o,
  input  logic              b_valid_i,
  input  axi_resp_t         b_resp_i,
  output logic              b_ready_o
);

  // Request registers cross unsynchronized since they are stable in flight
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  lane_mask_t        req_strb;
  axi_size_t         req_size;
  logic              req_write;
  // Toggle handshake in both directions
  logic              str_toggle;
  logic              start_pulse;
  logic              done_toggle;
  logic              done_pulse;

  dbg_cmd_port #(
    .ADDR_W (ADDR_W)
  ) u_cmd_port (
    .tck_i        (tck_i),
    .trstn_i      (trstn_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .word_size_i  (word_size_i),
    .rd_wrn_i     (rd_wrn_i),
    .strobe_i     (strobe_i),
    .rdy_o        (rdy_o),
    .done_pulse_i (done_pulse),
    .str_toggle_o (str_toggle),
    .req_addr_o   (req_addr),
    .req_wdata_o  (req_wdata),
    .req_strb_o   (req_strb),
    .req_size_o   (req_size),
    .req_write_o  (req_write)
  );

  // Start into the AXI domain
  toggle_sync u_str_sync (
    .clk_i    (axi_aclk),
    .rst_ni   (axi_aresetn),
    .toggle_i (str_toggle),
    .pulse_o  (start_pulse)
  );

  // Completion back into the TCK domain
  toggle_sync u_done_sync (
    .clk_i    (tck_i),
    .rst_ni   (trstn_i),
    .toggle_i (done_toggle),
    .pulse_o  (done_pulse)
  );

  axi_access_fsm #(
    .ADDR_W (ADDR_W)
  ) u_access_fsm (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .start_pulse_i (start_pulse),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .req_strb_i    (req_strb),
    .req_size_i    (req_size),
    .req_write_i   (req_write),
    .aw_valid_o    (aw_valid_o),
    .aw_addr_o     (aw_addr_o),
    .aw_size_o     (aw_size_o),
    .aw_ready_i    (aw_ready_i),
    .w_valid_o     (w_valid_o),
    .w_data_o      (w_data_o),
    .w_strb_o      (w_strb_o),
    .w_ready_i     (w_ready_i),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .ar_size_o     (ar_size_o),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_resp_i      (r_resp_i),
    .r_ready_o     (r_ready_o),
    .b_valid_i     (b_valid_i),
    .b_resp_i      (b_resp_i),
    .b_ready_o     (b_ready_o),
    // Result is held until the next completion
    .rdata_o       (data_o),
    .err_o         (err_o),
    .done_toggle_o (done_toggle)
  );

endmodule

`default_nettype wire

/* hw/dbg_cmd_port.sv */
`default_nettype none
`timescale 1ns/100ps

module dbg_cmd_port
  import dbg_req_pkg::*;
  import axi_lite_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              tck_i,
  input  logic              trstn_i,
  // Debug request
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] data_i,
  input  word_size_t        word_size_i,
  input  logic              rd_wrn_i,
  input  logic              strobe_i,
  output logic              rdy_o,
  // Completion from the AXI side, already synchronized
  input  logic              done_pulse_i,
  // Start level toward the AXI side
  output logic              str_toggle_o,
  // Captured request, held while the access is in flight
  output logic [ADDR_W-1:0] req_addr_o,
  output logic [DATA_W-1:0] req_wdata_o,
  output lane_mask_t        req_strb_o,
  output axi_size_t         req_size_o,
  output logic              req_write_o
);

  //////////////////////////////
  // Request decode
  //////////////////////////////

  logic              accept;
  logic [3:0]        nbytes;
  lane_off_t         wr_off;
  lane_mask_t        strb_dec;
  axi_size_t         size_dec;
  logic [DATA_W-1:0] wdata_top;
  logic [DATA_W-1:0] wdata_dec;

  // Strobes while busy are dropped
  assign accept = strobe_i & rdy_o;

  assign nbytes   = size_bytes(word_size_i);
  assign wr_off   = lane_offset(addr_i[OFF_W-1:0], word_size_i);
  assign strb_dec = lane_mask(addr_i[OFF_W-1:0], word_size_i);

  // Byte count to AXI size code
  always_comb
  begin
    case (nbytes)
      4'd1:    size_dec = 3'd0;
      4'd2:    size_dec = 3'd1;
      4'd4:    size_dec = 3'd2;
      default: size_dec = 3'd3;
    endcase
  end

  // Short words arrive in the top bytes of data_i
  // Bring them down to lane 0 first
  assign wdata_top = data_i >> {(4'(LANES) - nbytes), 3'b000};
  // Then up to their lane offset, little-endian
  assign wdata_dec = wdata_top << {wr_off, 3'b000};

  //////////////////////////////
  // Request registers
  //////////////////////////////

  // Payload only loads on acceptance
  always_ff @(posedge tck_i)
  begin
    if (accept)
    begin
      req_addr_o  <= addr_i;
      req_wdata_o <= wdata_dec;
      req_strb_o  <= strb_dec;
      req_size_o  <= size_dec;
      req_write_o <= ~rd_wrn_i;
    end
  end

  //////////////////////////////
  // Handshake with AXI side
  //////////////////////////////

  // One flip per accepted request
  always_ff @(posedge tck_i, negedge trstn_i)
  begin
    if (!trstn_i)
      str_toggle_o <= 1'b0;
    else if (accept)
      str_toggle_o <= ~str_toggle_o;
  end

  // Ready drops on acceptance
  // Comes back the cycle after the completion pulse
  always_ff @(posedge tck_i, negedge trstn_i)
  begin
    if (!trstn_i)
      rdy_o <= 1'b1;
    else if (accept)
      rdy_o <= 1'b0;
    else if (done_pulse_i)
      rdy_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* hw/dbg_req_pkg.sv */
`default_nettype none

package dbg_req_pkg;

  // Debug and AXI data path width
  localparam int DATA_W = 64;
  localparam int LANES  = DATA_W / 8;
  // Bits needed to index one byte lane
  localparam int OFF_W  = $clog2(LANES);

  // Word size code from the debug side (1, 2, 4 or 8)
  typedef logic [3:0]       word_size_t;
  typedef logic [LANES-1:0] lane_mask_t;
  typedef logic [OFF_W-1:0] lane_off_t;

  // Unknown codes fall back to a full 64-bit word
  function automatic logic [3:0] size_bytes(input word_size_t ws);
    case (ws)
      4'd1, 4'd2, 4'd4: return ws;
      default:          return 4'd8;
    endcase
  endfunction

  // Low address bits aligned down to the access size
  function automatic lane_off_t lane_offset(input lane_off_t addr_lo, input word_size_t ws);
    lane_off_t size_m1;
    size_m1 = lane_off_t'(size_bytes(ws) - 4'd1);
    return addr_lo & ~size_m1;
  endfunction

  // One strobe bit per byte touched, starting at the lane offset
  function automatic lane_mask_t lane_mask(input lane_off_t addr_lo, input word_size_t ws);
    logic [LANES:0] ones;
    ones = ({{LANES{1'b0}}, 1'b1} << size_bytes(ws)) - {{LANES{1'b0}}, 1'b1};
    return lane_mask_t'(ones[LANES-1:0]) << lane_offset(addr_lo, ws);
  endfunction

endpackage

`default_nettype wire

/* hw/toggle_sync.sv */
`default_nettype none
`timescale 1ns/100ps

module toggle_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic toggle_i,
  output logic pulse_o
);

  // Two metastability flops plus one history flop
  logic sync1_q;
  logic sync2_q;
  logic sync3_q;

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
    end
    else
    begin
      sync1_q <= toggle_i;
      sync2_q <= sync1_q;
      // Previous settled value for edge detection
      sync3_q <= sync2_q;
    end
  end

  // Any change of the source level gives one destination cycle
  assign pulse_o = sync2_q ^ sync3_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_dbg_axi_biu \
  -f sim.f \
  -o tb_dbg_axi_biu_sim

# The run may stop early on an assertion, so the log decides
./obj_dir/tb_dbg_axi_biu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi

/* sim.f */
hw/dbg_req_pkg.sv
hw/axi_lite_pkg.sv
hw/toggle_sync.sv
hw/dbg_cmd_port.sv
hw/axi_access_fsm.sv
hw/dbg_axi_biu.sv
verif/tb_clk_gen.sv
verif/dbg_axi_biu_chk.sv
verif/tb_dbg_axi_biu.sv

/* verif/dbg_axi_biu_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module dbg_axi_biu_chk
  import dbg_req_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              rdy_i,
  input logic              aw_valid_i,
  input logic              aw_ready_i,
  input logic [ADDR_W-1:0] aw_addr_i,
  input logic [2:0]        aw_size_i,
  input logic              w_valid_i,
  input logic              w_ready_i,
  input logic [DATA_W-1:0] w_data_i,
  input logic [LANES-1:0]  w_strb_i,
  input logic              ar_valid_i,
  input logic              ar_ready_i,
  input logic [ADDR_W-1:0] ar_addr_i,
  input logic [2:0]        ar_size_i,
  input logic              r_ready_i,
  input logic              b_ready_i
);

  //////////////////////////////
  // Reset state
  //////////////////////////////

  // No valid or ready driven while in reset
  assert property (@(posedge clk_i)
    !rst_ni |-> !(aw_valid_i || w_valid_i || ar_valid_i || r_ready_i || b_ready_i))
    else $error("AXI valid or ready high during reset");

  //////////////////////////////
  // Back-pressure
  //////////////////////////////

  // Address and payload held until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i) && $stable(aw_size_i))
    else $error("aw channel dropped or changed before aw_ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
    else $error("w channel dropped or changed before w_ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_size_i))
    else $error("ar channel dropped or changed before ar_ready");

  // Debug side busy whenever a transfer is on the bus
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (aw_valid_i || w_valid_i || ar_valid_i) |-> !rdy_i)
    else $error("rdy_o high while an AXI transfer is in flight");

endmodule

bind dbg_axi_biu dbg_axi_biu_chk #(
  .ADDR_W (ADDR_W)
) u_chk (
  .clk_i      (axi_aclk),
  .rst_ni     (axi_aresetn),
  .rdy_i      (rdy_o),
  .aw_valid_i (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .aw_addr_i  (aw_addr_o),
  .aw_size_i  (aw_size_o),
  .w_valid_i  (w_valid_o),
  .w_ready_i  (w_ready_i),
  .w_data_i   (w_data_o),
  .w_strb_i   (w_strb_o),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_addr_i  (ar_addr_o),
  .ar_size_i  (ar_size_o),
  .r_ready_i  (r_ready_o),
  .b_ready_i  (b_ready_o)
);

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock starting low
  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Active-low reset held for a few cycles, released on a falling edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_dbg_axi_biu.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_dbg_axi_biu;

  // Clocks and resets
  logic        axi_aclk;
  logic        axi_aresetn;
  logic        tck;
  logic        trstn;
  // Debug side
  logic [31:0] addr_i;
  logic [63:0] data_i;
  logic [3:0]  word_size_i;
  logic        rd_wrn_i;
  logic        strobe_i;
  logic [63:0] data_o;
  logic        rdy_o;
  logic        err_o;
  // AXI side
  logic        aw_valid_o;
  logic [31:0] aw_addr_o;
  logic [2:0]  aw_size_o;
  logic        aw_ready_i;
  logic        w_valid_o;
  logic [63:0] w_data_o;
  logic [7:0]  w_strb_o;
  logic        w_ready_i;
  logic        ar_valid_o;
  logic [31:0] ar_addr_o;
  logic [2:0]  ar_size_o;
  logic        ar_ready_i;
  logic        r_valid_i;
  logic [63:0] r_data_i;
  logic [1:0]  r_resp_i;
  logic        r_ready_o;
  logic        b_valid_i;
  logic [1:0]  b_resp_i;
  logic        b_ready_o;

  // Responder and scoreboard state
  logic [7:0]  lfsr_q = 8'd68;
  logic        resp_err;
  logic        slow;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic        r_hs;
  logic        b_hs;
  logic        aw_got;
  logic        w_got;
  logic        ar_got;
  int          b_wait;
  int          r_wait;
  int          aw_count;
  int          w_count;
  int          ar_count;
  logic [31:0] seen_aw_addr;
  logic [31:0] seen_ar_addr;
  logic [2:0]  seen_aw_size;
  logic [2:0]  seen_ar_size;
  logic [63:0] seen_w_data;
  logic [63:0] last_rdata;
  logic [7:0]  seen_w_strb;
  int          errors;
  int          tests;
  int          passed;

  // Timeout handling
  event        timeout_ev;
  string       timeout_what;

  tb_clk_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (2)
  ) u_axi_clk (
    .clk_o  (axi_aclk),
    .rst_no (axi_aresetn)
  );

  tb_clk_gen #(
    .PERIOD_NS    (50),
    .RESET_CYCLES (2)
  ) u_tck_clk (
    .clk_o  (tck),
    .rst_no (trstn)
  );

  dbg_axi_biu #(
    .ADDR_W (32)
  ) dut_i (
    .tck_i       (tck),
    .trstn_i     (trstn),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .word_size_i (word_size_i),
    .rd_wrn_i    (rd_wrn_i),
    .strobe_i    (strobe_i),
    .data_o      (data_o),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .aw_valid_o  (aw_valid_o),
    .aw_addr_o   (aw_addr_o),
    .aw_size_o   (aw_size_o),
    .aw_ready_i  (aw_ready_i),
    .w_valid_o   (w_valid_o),
    .w_data_o    (w_data_o),
    .w_strb_o    (w_strb_o),
    .w_ready_i   (w_ready_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_size_o   (ar_size_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_resp_i    (r_resp_i),
    .r_ready_o   (r_ready_o),
    .b_valid_i   (b_valid_i),
    .b_resp_i    (b_resp_i),
    .b_ready_o   (b_ready_o)
  );

  //////////////////////////////
  // Random source and expected values
  //////////////////////////////

  // 8-bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[62:0], lfsr_bit()};
    return v;
  endfunction

  // Slow mode needs two ones in a row
  function automatic logic rand_ready();
    if (slow)
      return rand_bits(2) == 64'd3;
    return rand_bits(1) == 64'd1;
  endfunction

  function automatic int exp_bytes(input logic [3:0] ws);
    if (ws == 4'd1 || ws == 4'd2 || ws == 4'd4)
      return int'(ws);
    return 8;
  endfunction

  // Low address bits rounded down to the access size
  function automatic int exp_off(input logic [2:0] lo, input logic [3:0] ws);
    return int'(lo) - (int'(lo) % exp_bytes(ws));
  endfunction

  function automatic logic [7:0] exp_mask(input int off, input int n);
    logic [7:0] m;
    for (int i = 0; i < 8; i++)
      m[i] = (i >= off) && (i < off + n);
    return m;
  endfunction

  // Top n bytes of the debug word land at lane off and up
  function automatic logic [63:0] exp_wdata(input logic [63:0] d, input int off, input int n);
    logic [63:0] w;
    w = '0;
    for (int b = 0; b < n; b++)
      w[8*(off+b) +: 8] = d[8*(8-n+b) +: 8];
    return w;
  endfunction

  function automatic logic [2:0] exp_size(input int n);
    case (n)
      1:       return 3'd0;
      2:       return 3'd1;
      4:       return 3'd2;
      default: return 3'd3;
    endcase
  endfunction

  //////////////////////////////
  // AXI responder
  //////////////////////////////

  // Handshakes and payloads seen at the rising edge
  always @(posedge axi_aclk)
  begin
    aw_hs <= aw_valid_o && aw_ready_i;
    w_hs  <= w_valid_o && w_ready_i;
    ar_hs <= ar_valid_o && ar_ready_i;
    r_hs  <= r_valid_i && r_ready_o;
    b_hs  <= b_valid_i && b_ready_o;
    if (aw_valid_o && aw_ready_i)
    begin
      aw_count     <= aw_count + 1;
      seen_aw_addr <= aw_addr_o;
      seen_aw_size <= aw_size_o;
    end
    if (w_valid_o && w_ready_i)
    begin
      w_count     <= w_count + 1;
      seen_w_data <= w_data_o;
      seen_w_strb <= w_strb_o;
    end
    if (ar_valid_o && ar_ready_i)
    begin
      ar_count     <= ar_count + 1;
      seen_ar_addr <= ar_addr_o;
      seen_ar_size <= ar_size_o;
    end
  end

  // Responses driven on the falling edge with random delays
  always @(negedge axi_aclk)
  begin
    if (aw_hs)
      aw_got = 1'b1;
    if (w_hs)
      w_got = 1'b1;
    if (aw_hs || w_hs)
      b_wait = int'(rand_bits(2));
    aw_ready_i = !aw_got && !aw_hs && rand_ready();
    w_ready_i  = !w_got && !w_hs && rand_ready();
    if (b_hs)
    begin
      b_valid_i = 1'b0;
      aw_got    = 1'b0;
      w_got     = 1'b0;
    end
    else if (aw_got && w_got && !b_valid_i)
    begin
      if (b_wait == 0)
      begin
        b_valid_i = 1'b1;
        b_resp_i  = resp_err ? 2'b10 : 2'b00;
      end
      else
        b_wait--;
    end
    // Read side
    if (ar_hs)
    begin
      ar_got = 1'b1;
      r_wait = int'(rand_bits(2));
    end
    ar_ready_i = !ar_got && !ar_hs && rand_ready();
    if (r_hs)
    begin
      r_valid_i = 1'b0;
      ar_got    = 1'b0;
    end
    else if (ar_got && !r_valid_i)
    begin
      if (r_wait == 0)
      begin
        r_valid_i  = 1'b1;
        r_data_i   = rand_bits(64);
        r_resp_i   = resp_err ? 2'b11 : 2'b00;
        last_rdata = r_data_i;
      end
      else
        r_wait--;
    end
  end

  //////////////////////////////
  // Test tasks
  //////////////////////////////

  task automatic check(input logic cond, input string msg);
    assert (cond)
    else
    begin
      $display("Fail %0t: %s", $time, msg);
      errors++;
    end
  endtask

  // Stuck wait is reported by the watchdog process below
  task automatic timeout_fail(input string what);
    timeout_what = what;
    -> timeout_ev;
  endtask

  // Ends the run when any wait loop gives up
  initial
  begin
    @(timeout_ev);
    $display("Timeout while waiting for %s", timeout_what);
    $display("SIMULATION FAILED");
    $finish;
  end

  // One debug access checked against the lane rules on completion
  task automatic run_access(input string name, input logic write, input logic [31:0] addr,
                            input logic [3:0] ws, input logic err, input logic busy);
    logic [63:0] data;
    int          aw0;
    int          w0;
    int          ar0;
    int          cnt;
    int          n;
    int          off;
    int          bad0;
    data     = rand_bits(64);
    resp_err = err;
    bad0     = errors;
    cnt      = 0;
    while (!rdy_o)
    begin
      if (cnt == 400)
        timeout_fail("rdy_o before a request");
      @(negedge tck);
      cnt++;
    end
    aw0 = aw_count;
    w0  = w_count;
    ar0 = ar_count;
    addr_i      = addr;
    data_i      = data;
    word_size_i = ws;
    rd_wrn_i    = !write;
    strobe_i    = 1'b1;
    @(negedge tck);
    strobe_i = 1'b0;
    check(!rdy_o, "rdy_o still high after acceptance");
    // Strobe while busy must be dropped
    if (busy)
    begin
      addr_i   = addr ^ 32'h100;
      rd_wrn_i = write;
      strobe_i = 1'b1;
      repeat (2) @(negedge tck);
      strobe_i = 1'b0;
    end
    cnt = 0;
    while (!rdy_o)
    begin
      if (cnt == 400)
        timeout_fail("rdy_o after a request");
      @(negedge tck);
      cnt++;
    end
    n   = exp_bytes(ws);
    off = exp_off(addr[2:0], ws);
    if (write)
    begin
      check(aw_count == aw0 + 1 && w_count == w0 + 1, "write not seen exactly once");
      check(ar_count == ar0, "unexpected read on a write");
      check(seen_aw_addr == addr, "aw_addr differs from addr_i");
      check(seen_aw_size == exp_size(n), "aw_size wrong");
      check(seen_w_strb == exp_mask(off, n), "w_strb wrong");
      check(seen_w_data == exp_wdata(data, off, n), "w_data wrong");
    end
    else
    begin
      check(ar_count == ar0 + 1 && aw_count == aw0, "read not seen exactly once");
      check(seen_ar_addr == addr, "ar_addr differs from addr_i");
      check(seen_ar_size == exp_size(n), "ar_size wrong");
      check(data_o == (last_rdata >> (8 * off)), "data_o wrong");
    end
    check(err_o == err, "err_o wrong");
    if (busy)
    begin
      repeat (8) @(negedge tck);
      check(rdy_o, "rdy_o dropped after the busy strobe");
      check(aw_count + ar_count == aw0 + ar0 + 1, "busy strobe started a transfer");
    end
    tests++;
    if (errors == bad0)
    begin
      passed++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: failed", name);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    int         cnt;
    logic [3:0] sizes [4];
    sizes = '{4'd1, 4'd2, 4'd4, 4'd8};
    addr_i      = '0;
    data_i      = '0;
    word_size_i = 4'd8;
    rd_wrn_i    = 1'b1;
    strobe_i    = 1'b0;
    aw_ready_i  = 1'b0;
    w_ready_i   = 1'b0;
    ar_ready_i  = 1'b0;
    r_valid_i   = 1'b0;
    r_data_i    = '0;
    r_resp_i    = 2'b00;
    b_valid_i   = 1'b0;
    b_resp_i    = 2'b00;
    resp_err    = 1'b0;
    slow        = 1'b0;
    aw_got      = 1'b0;
    w_got       = 1'b0;
    ar_got      = 1'b0;
    b_wait      = 0;
    r_wait      = 0;
    errors      = 0;
    tests       = 0;
    passed      = 0;
    cnt         = 0;
    while (!(trstn && axi_aresetn))
    begin
      if (cnt == 50)
        timeout_fail("reset release");
      @(negedge tck);
      cnt++;
    end
    @(negedge tck);
    check(rdy_o, "rdy_o low after reset");
    check(!(aw_valid_o || w_valid_o || ar_valid_o || r_ready_o || b_ready_o),
          "AXI outputs active after reset");
    tests++;
    if (errors == 0)
    begin
      passed++;
      $display("test reset: ok");
    end
    else
      $display("test reset: failed");
    for (int k = 0; k < 8; k++)
      run_access($sformatf("write size %0d", sizes[k%4]), 1'b1, 32'(rand_bits(32)),
                 sizes[k%4], 1'b0, 1'b0);
    // Unknown size code is a full word
    run_access("write size code 3", 1'b1, 32'(rand_bits(32)), 4'd3, 1'b0, 1'b0);
    for (int k = 0; k < 8; k++)
      run_access($sformatf("read size %0d", sizes[k%4]), 1'b0, 32'(rand_bits(32)),
                 sizes[k%4], 1'b0, 1'b0);
    run_access("write error", 1'b1, 32'(rand_bits(32)), 4'd4, 1'b1, 1'b0);
    run_access("read error", 1'b0, 32'(rand_bits(32)), 4'd2, 1'b1, 1'b0);
    run_access("read okay after error", 1'b0, 32'(rand_bits(32)), 4'd8, 1'b0, 1'b0);
    slow = 1'b1;
    run_access("write back-pressure", 1'b1, 32'(rand_bits(32)), 4'd2, 1'b0, 1'b1);
    run_access("read back-pressure", 1'b0, 32'(rand_bits(32)), 4'd1, 1'b0, 1'b1);
    $display("tests %0d passed %0d errors %0d", tests, passed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
